/* glb_cfg.f */
hdl/glb_cfg_pkg.sv
hdl/glb_dma_pkg.sv
hdl/glb_wb_cfg_bridge.sv
hdl/glb_tile_cfg.sv
hdl/glb_tile_store_dma.sv
hdl/glb_tile_bank.sv
hdl/glb_tile.sv
hdl/glb_cfg_top.sv
test/glb_cfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f glb_cfg.f --top-module glb_cfg_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vglb_cfg_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* test/glb_cfg_tb.sv */
// Assumes four tiles and a bridge read timeout of 32 cycles; bank words are read only where written.
module glb_cfg_tb
    import glb_cfg_pkg::*;
();

    localparam int WB_LIMIT    = 64; // longer than the bridge read timeout.
    localparam int PUSH_LIMIT  = 40;
    localparam int STALL_LIMIT = 20;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PUSH, OP_STALL} op_t;

    logic                      clk;
    logic                      reset;
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [CFG_ADDR_WIDTH-1:0] adr;
    logic [CFG_DATA_WIDTH-1:0] dat_w;
    logic [CFG_DATA_WIDTH-1:0] dat_r;
    logic                      ack;
    logic                      strm_valid;
    logic [CFG_DATA_WIDTH-1:0] strm_data;
    logic [TILE_SEL_WIDTH-1:0] strm_tile;
    logic                      strm_ready;

    logic [15:0] lfsr_state = 16'd36;
    int          errors     = 0;
    int          checks     = 0;

    // stimulus table, one entry per row in each queue.
    string                     row_name [$];
    op_t                       row_op   [$];
    logic [CFG_ADDR_WIDTH-1:0] row_addr [$]; // tile number for stream rows.
    logic [CFG_DATA_WIDTH-1:0] row_data [$];
    logic [CFG_DATA_WIDTH-1:0] row_exp  [$];

    glb_cfg_top #(.NUM_TILES(4), .RD_TIMEOUT(32)) glb_cfg_top_inst (
        .clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .strm_valid, .strm_data, .strm_tile, .strm_ready
    );

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 16, 14, 13 and 11, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [CFG_ADDR_WIDTH-1:0] cfg_addr(input bit bank, input int tile,
                                                         input int idx);
        cfg_addr_t a;
        a              = '0;
        a.bank.is_bank = bank;
        a.bank.tile    = TILE_SEL_WIDTH'(tile);
        if (bank) begin
            a.bank.word = 7'(idx);
        end else begin
            a.regs.reg_idx = 5'(idx);
        end
        return a;
    endfunction

    // register 1 alternates auto mode by tile and keeps DMA off, other fields differ per tile.
    function automatic logic [31:0] pattern(input int t, input int r);
        logic [31:0] d;
        d = {16'hC0DE, 8'(t * 13 + r), 8'(t * 41 + r * 7 + 1)};
        if (r == 1) begin
            d[1:0] = {t[0], 1'b0};
        end
        return d;
    endfunction

    task automatic add_row(input string name, input op_t op, input logic [15:0] a,
                           input logic [31:0] d, input logic [31:0] e);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(a);
        row_data.push_back(d);
        row_exp.push_back(e);
    endtask

    task automatic add_header(input int tile, input int h, input int start, input int count);
        add_row("header count", OP_WR, cfg_addr(1'b0, tile, 2 + 2 * h), 32'(count), '0);
        add_row("header valid", OP_WR, cfg_addr(1'b0, tile, 3 + 2 * h),
                {24'd0, 7'(start), 1'b1}, '0);
    endtask

    // pushes random words, then reads them back from the bank, which wraps at 128 words.
    task automatic add_transfer(input int tile, input int start, input int count);
        logic [31:0] w [8];
        for (int i = 0; i < count; i++) begin
            w[i] = rand_bits(32);
            add_row($sformatf("push t%0d word %0d", tile, i), OP_PUSH, 16'(tile), w[i], '0);
        end
        for (int i = 0; i < count; i++) begin
            add_row($sformatf("bank t%0d word %0d", tile, (start + i) % 128), OP_RD,
                    cfg_addr(1'b1, tile, (start + i) % 128), '0, w[i]);
        end
    endtask

    task automatic wb_access(input logic is_write, input logic [15:0] a, input logic [31:0] d,
                             output logic [31:0] rdata);
        int n;
        bit seen;
        n     = 0;
        seen  = 1'b0;
        rdata = '0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= is_write;
        adr   <= a;
        dat_w <= d;
        while (!seen && n < WB_LIMIT) begin
            @(negedge clk);
            seen  = ack;
            rdata = dat_r; // dat_r is valid in the ack cycle.
            n++;
        end
        assert (seen) else begin
            errors++;
            $display("Wishbone access at address %04h was never acknowledged", a);
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic push_word(input logic [3:0] tile, input logic [31:0] word, input int limit,
                             output bit taken);
        int n;
        n     = 0;
        taken = 1'b0;
        @(posedge clk);
        strm_valid <= 1'b1;
        strm_tile  <= tile;
        strm_data  <= word;
        while (!taken && n < limit) begin
            @(negedge clk);
            taken = strm_ready;
            n++;
        end
        @(posedge clk);
        strm_valid <= 1'b0; // the word transfers on this edge when ready was seen.
    endtask

    initial begin
        logic [31:0] got;
        bit          taken;
        int          gap;
        clk   = 1'b0;
        reset = 1'b1;
        {cyc, stb, we, strm_valid} = '0;
        {adr, dat_w, strm_data, strm_tile} = '0;

        for (int t = 0; t < 4; t++) begin
            for (int r = 0; r < 10; r++) begin
                add_row($sformatf("reset t%0d r%0d", t, r), OP_RD, cfg_addr(1'b0, t, r), '0, '0);
                add_row("write", OP_WR, cfg_addr(1'b0, t, r), pattern(t, r), '0);
            end
        end
        add_row("unmapped write", OP_WR, cfg_addr(1'b0, 0, 12), 32'hFFFF_FFFF, '0);
        add_row("unmapped read", OP_RD, cfg_addr(1'b0, 0, 12), '0, '0);
        for (int r = 0; r < 10; r++) begin
            add_row("absent tile write", OP_WR, cfg_addr(1'b0, 7, r), 32'hFFFF_FFFF, '0);
        end
        add_row("absent tile read", OP_RD, cfg_addr(1'b0, 7, 0), '0, '0);
        for (int t = 0; t < 4; t++) begin
            for (int r = 0; r < 10; r++) begin
                add_row($sformatf("readback t%0d r%0d", t, r), OP_RD, cfg_addr(1'b0, t, r), '0,
                        pattern(t, r) & (r < 2 ? 32'h3 : 32'hFF));
                add_row("clear", OP_WR, cfg_addr(1'b0, t, r), '0, '0);
            end
        end

        add_header(2, 0, 125, 5);
        add_row("t2 dma on", OP_WR, cfg_addr(1'b0, 2, 1), 32'd1, '0);
        add_transfer(2, 125, 5);
        add_row("t2 h0 cleared", OP_RD, cfg_addr(1'b0, 2, 3), '0, {24'd0, 7'd125, 1'b0});
        add_header(1, 0, 10, 3);
        add_header(1, 1, 20, 2);
        add_row("t1 dma on", OP_WR, cfg_addr(1'b0, 1, 1), 32'd1, '0);
        add_transfer(1, 10, 3);
        add_transfer(1, 20, 2);
        add_row("t1 h0 cleared", OP_RD, cfg_addr(1'b0, 1, 3), '0, {24'd0, 7'd10, 1'b0});
        add_row("t1 h1 cleared", OP_RD, cfg_addr(1'b0, 1, 5), '0, {24'd0, 7'd20, 1'b0});
        add_row("t1 auto on", OP_WR, cfg_addr(1'b0, 1, 1), 32'd3, '0);
        add_header(1, 2, 0, 0); // empty headers are skipped, which brings the slot back to 0.
        add_header(1, 3, 0, 0);
        add_row("t1 h2 skipped", OP_RD, cfg_addr(1'b0, 1, 7), '0, '0);
        add_row("t1 h3 skipped", OP_RD, cfg_addr(1'b0, 1, 9), '0, '0);
        add_header(1, 0, 40, 2);
        add_transfer(1, 40, 2);
        add_row("t1 h0 kept", OP_RD, cfg_addr(1'b0, 1, 3), '0, {24'd0, 7'd40, 1'b1});
        add_row("t3 stall", OP_STALL, 16'd3, 32'h0BAD_F00D, '0);

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < row_op.size(); i++) begin
            case (row_op[i])
                OP_WR: begin
                    wb_access(1'b1, row_addr[i], row_data[i], got);
                end
                OP_RD: begin
                    wb_access(1'b0, row_addr[i], '0, got);
                    checks++;
                    assert (got === row_exp[i]) else begin
                        errors++;
                        $display("ERROR %s: expected %08h, actual %08h", row_name[i],
                                 row_exp[i], got);
                    end
                end
                OP_PUSH: begin
                    gap = int'(rand_bits(2));
                    repeat (gap) @(posedge clk);
                    push_word(row_addr[i][3:0], row_data[i], PUSH_LIMIT, taken);
                    assert (taken) else begin
                        errors++;
                        $display("%s: the tile never raised ready for the stream word",
                                 row_name[i]);
                    end
                end
                default: begin
                    push_word(row_addr[i][3:0], row_data[i], STALL_LIMIT, taken);
                    assert (!taken) else begin
                        errors++;
                        $display("%s: a tile with its DMA off accepted a word", row_name[i]);
                    end
                    if (!taken) begin
                        $display("%s: expected stall, ready stayed low for %0d cycles",
                                 row_name[i], STALL_LIMIT);
                    end
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hdl/glb_cfg_top.sv */
// Bridge at the east end and a chain of NUM_TILES tiles; requests past the last tile are dropped.
module glb_cfg_top
    import glb_cfg_pkg::*;
#(
    parameter int NUM_TILES  = 4,
    parameter int RD_TIMEOUT = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [CFG_ADDR_WIDTH-1:0] adr,
    input  logic [CFG_DATA_WIDTH-1:0] dat_w,
    output logic [CFG_DATA_WIDTH-1:0] dat_r,
    output logic                      ack,
    input  logic                      strm_valid,
    input  logic [CFG_DATA_WIDTH-1:0] strm_data,
    input  logic [TILE_SEL_WIDTH-1:0] strm_tile,
    output logic                      strm_ready
);

    // index k is the east side of tile k, and k+1 its west side.
    logic                      wr_en         [NUM_TILES+1];
    cfg_addr_t                 wr_addr       [NUM_TILES+1];
    logic [CFG_DATA_WIDTH-1:0] wr_data       [NUM_TILES+1];
    logic                      rd_en         [NUM_TILES+1];
    cfg_addr_t                 rd_addr       [NUM_TILES+1];
    logic [CFG_DATA_WIDTH-1:0] rd_data       [NUM_TILES+1];
    logic                      rd_data_valid [NUM_TILES+1];
    logic [NUM_TILES-1:0]      tile_ready;

    glb_wb_cfg_bridge #(.RD_TIMEOUT(RD_TIMEOUT)) glb_wb_cfg_bridge_inst (
        .clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .cfg_wr_en(wr_en[0]), .cfg_wr_addr(wr_addr[0]), .cfg_wr_data(wr_data[0]),
        .cfg_rd_en(rd_en[0]), .cfg_rd_addr(rd_addr[0]),
        .cfg_rd_data(rd_data[0]), .cfg_rd_data_valid(rd_data_valid[0])
    );

    assign rd_data[NUM_TILES]       = '0; // nothing answers from beyond the last tile.
    assign rd_data_valid[NUM_TILES] = 1'b0;

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(.TILE_ID(k)) glb_tile_inst (
            .clk, .reset,
            .est_wr_en(wr_en[k]), .est_wr_addr(wr_addr[k]), .est_wr_data(wr_data[k]),
            .est_rd_en(rd_en[k]), .est_rd_addr(rd_addr[k]),
            .est_rd_data(rd_data[k]), .est_rd_data_valid(rd_data_valid[k]),
            .wst_wr_en(wr_en[k+1]), .wst_wr_addr(wr_addr[k+1]), .wst_wr_data(wr_data[k+1]),
            .wst_rd_en(rd_en[k+1]), .wst_rd_addr(rd_addr[k+1]),
            .wst_rd_data(rd_data[k+1]), .wst_rd_data_valid(rd_data_valid[k+1]),
            .strm_valid, .strm_data, .strm_tile, .strm_ready(tile_ready[k])
        );
    end

    assign strm_ready = |tile_ready; // at most the addressed tile raises ready.

endmodule

/* hdl/glb_tile.sv */
// One buffer tile; the start and end flags are kept for fabric-side logic outside this design.
module glb_tile
    import glb_cfg_pkg::*;
    import glb_dma_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      est_wr_en,
    input  cfg_addr_t                 est_wr_addr,
    input  logic [CFG_DATA_WIDTH-1:0] est_wr_data,
    input  logic                      est_rd_en,
    input  cfg_addr_t                 est_rd_addr,
    output logic [CFG_DATA_WIDTH-1:0] est_rd_data,
    output logic                      est_rd_data_valid,
    output logic                      wst_wr_en,
    output cfg_addr_t                 wst_wr_addr,
    output logic [CFG_DATA_WIDTH-1:0] wst_wr_data,
    output logic                      wst_rd_en,
    output cfg_addr_t                 wst_rd_addr,
    input  logic [CFG_DATA_WIDTH-1:0] wst_rd_data,
    input  logic                      wst_rd_data_valid,
    input  logic                      strm_valid,
    input  logic [CFG_DATA_WIDTH-1:0] strm_data,
    input  logic [TILE_SEL_WIDTH-1:0] strm_tile,
    output logic                      strm_ready
);

    logic                      store_dma_on;
    logic                      store_dma_auto_on;
    dma_st_header_t            store_dma_header [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0]    store_dma_invalidate_pulse;
    logic [GLB_ADDR_WIDTH-1:0] bank_rd_addr;
    logic [CFG_DATA_WIDTH-1:0] bank_rd_data;
    logic                      bank_wr_en;
    logic [GLB_ADDR_WIDTH-1:0] bank_wr_addr;
    logic [CFG_DATA_WIDTH-1:0] bank_wr_data;

    glb_tile_cfg #(.TILE_ID(TILE_ID)) glb_tile_cfg_inst (
        .clk, .reset,
        .est_wr_en, .est_wr_addr, .est_wr_data, .est_rd_en, .est_rd_addr,
        .est_rd_data, .est_rd_data_valid,
        .wst_wr_en, .wst_wr_addr, .wst_wr_data, .wst_rd_en, .wst_rd_addr,
        .wst_rd_data, .wst_rd_data_valid,
        .tile_is_start(), .tile_is_end(),
        .store_dma_on, .store_dma_auto_on, .store_dma_header, .store_dma_invalidate_pulse,
        .bank_rd_addr, .bank_rd_data
    );

    glb_tile_store_dma #(.TILE_ID(TILE_ID)) glb_tile_store_dma_inst (
        .clk, .reset,
        .store_dma_on, .store_dma_auto_on, .store_dma_header, .store_dma_invalidate_pulse,
        .strm_valid, .strm_data, .strm_tile, .strm_ready,
        .bank_wr_en, .bank_wr_addr, .bank_wr_data
    );

    glb_tile_bank glb_tile_bank_inst (
        .clk,
        .wr_en(bank_wr_en), .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
        .rd_addr(bank_rd_addr), .rd_data(bank_rd_data)
    );

endmodule

/* hdl/glb_tile_bank.sv */
// Tile word memory with a clocked write and a combinational read; contents are undefined until written.
module glb_tile_bank
    import glb_cfg_pkg::*;
    import glb_dma_pkg::*;
(
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0] wr_addr,
    input  logic [CFG_DATA_WIDTH-1:0] wr_data,
    input  logic [GLB_ADDR_WIDTH-1:0] rd_addr,
    output logic [CFG_DATA_WIDTH-1:0] rd_data
);

    logic [CFG_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr]; // read answer is registered in the router.

endmodule

/* hdl/glb_tile_store_dma.sv */
// Store DMA for one tile; serves header slots in queue order and holds ready low while idle.
module glb_tile_store_dma
    import glb_cfg_pkg::*;
    import glb_dma_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      store_dma_on,
    input  logic                      store_dma_auto_on,
    input  dma_st_header_t            store_dma_header [QUEUE_DEPTH],
    output logic [QUEUE_DEPTH-1:0]    store_dma_invalidate_pulse,
    input  logic                      strm_valid,
    input  logic [CFG_DATA_WIDTH-1:0] strm_data,
    input  logic [TILE_SEL_WIDTH-1:0] strm_tile,
    output logic                      strm_ready,
    output logic                      bank_wr_en,
    output logic [GLB_ADDR_WIDTH-1:0] bank_wr_addr,
    output logic [CFG_DATA_WIDTH-1:0] bank_wr_data
);

    logic [$clog2(QUEUE_DEPTH)-1:0] slot;
    logic                           busy;
    logic [GLB_ADDR_WIDTH-1:0]      wr_addr;
    logic [MAX_NUM_WORDS_WIDTH-1:0] words_left;
    dma_st_header_t                 cur_hdr;

    assign cur_hdr      = store_dma_header[slot];
    assign strm_ready   = busy && strm_tile == TILE_SEL_WIDTH'(TILE_ID);
    assign bank_wr_en   = strm_valid && strm_ready;
    assign bank_wr_addr = wr_addr;
    assign bank_wr_data = strm_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot                       <= '0;
            busy                       <= 1'b0;
            wr_addr                    <= '0;
            words_left                 <= '0;
            store_dma_invalidate_pulse <= '0;
        end else begin
            store_dma_invalidate_pulse <= '0;
            if (!busy) begin
                if (store_dma_on && cur_hdr.valid) begin
                    if (cur_hdr.num_words == '0) begin
                        store_dma_invalidate_pulse[slot] <= 1'b1; // empty header is dropped.
                        slot <= slot + 1'b1;
                    end else begin
                        busy       <= 1'b1;
                        wr_addr    <= cur_hdr.start_addr;
                        words_left <= cur_hdr.num_words;
                    end
                end
            end else if (bank_wr_en) begin
                wr_addr    <= wr_addr + 1'b1; // wraps at the end of the bank.
                words_left <= words_left - 1'b1;
                if (words_left == MAX_NUM_WORDS_WIDTH'(1)) begin
                    busy <= 1'b0;
                    store_dma_invalidate_pulse[slot] <= !store_dma_auto_on;
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) bank_wr_en |-> cur_hdr.valid)
        else $error("tile %0d stored a stream word without a valid header", TILE_ID);

endmodule

/* hdl/glb_tile_cfg.sv */
// Tile registers and router; requests for other tiles move west one stage per cycle, answers east.
module glb_tile_cfg
    import glb_cfg_pkg::*;
    import glb_dma_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      est_wr_en,
    input  cfg_addr_t                 est_wr_addr,
    input  logic [CFG_DATA_WIDTH-1:0] est_wr_data,
    input  logic                      est_rd_en,
    input  cfg_addr_t                 est_rd_addr,
    output logic [CFG_DATA_WIDTH-1:0] est_rd_data,
    output logic                      est_rd_data_valid,
    output logic                      wst_wr_en,
    output cfg_addr_t                 wst_wr_addr,
    output logic [CFG_DATA_WIDTH-1:0] wst_wr_data,
    output logic                      wst_rd_en,
    output cfg_addr_t                 wst_rd_addr,
    input  logic [CFG_DATA_WIDTH-1:0] wst_rd_data,
    input  logic                      wst_rd_data_valid,
    output logic                      tile_is_start,
    output logic                      tile_is_end,
    output logic                      store_dma_on,
    output logic                      store_dma_auto_on,
    output dma_st_header_t            store_dma_header [QUEUE_DEPTH],
    input  logic [QUEUE_DEPTH-1:0]    store_dma_invalidate_pulse,
    output logic [GLB_ADDR_WIDTH-1:0] bank_rd_addr,
    input  logic [CFG_DATA_WIDTH-1:0] bank_rd_data
);

    logic                      wr_match;
    logic                      rd_match;
    logic [CFG_DATA_WIDTH-1:0] rd_data_int;

    assign wr_match     = est_wr_en && est_wr_addr.regs.tile == TILE_SEL_WIDTH'(TILE_ID);
    assign rd_match     = est_rd_en && est_rd_addr.regs.tile == TILE_SEL_WIDTH'(TILE_ID);
    assign bank_rd_addr = est_rd_addr.bank.word;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_is_start     <= 1'b0;
            tile_is_end       <= 1'b0;
            store_dma_on      <= 1'b0;
            store_dma_auto_on <= 1'b0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                store_dma_header[i] <= '0;
            end
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (store_dma_invalidate_pulse[i]) begin
                    store_dma_header[i].valid <= 1'b0;
                end
            end
            // a register write below overrides an invalidate in the same cycle.
            if (wr_match && !est_wr_addr.regs.is_bank) begin
                case (est_wr_addr.regs.reg_idx)
                    5'd0: {tile_is_end, tile_is_start} <= est_wr_data[1:0];
                    5'd1: {store_dma_auto_on, store_dma_on} <= est_wr_data[1:0];
                    default: ;
                endcase
                for (int i = 0; i < QUEUE_DEPTH; i++) begin
                    if (est_wr_addr.regs.reg_idx == 5'(2 + 2 * i)) begin
                        store_dma_header[i].num_words <= est_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    end
                    if (est_wr_addr.regs.reg_idx == 5'(3 + 2 * i)) begin
                        {store_dma_header[i].start_addr, store_dma_header[i].valid} <=
                            est_wr_data[GLB_ADDR_WIDTH:0];
                    end
                end
            end
        end
    end

    always_comb begin
        rd_data_int = '0;
        if (est_rd_addr.regs.is_bank) begin
            rd_data_int = bank_rd_data;
        end else begin
            case (est_rd_addr.regs.reg_idx)
                5'd0: rd_data_int[1:0] = {tile_is_end, tile_is_start};
                5'd1: rd_data_int[1:0] = {store_dma_auto_on, store_dma_on};
                default: ;
            endcase
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (est_rd_addr.regs.reg_idx == 5'(2 + 2 * i)) begin
                    rd_data_int[MAX_NUM_WORDS_WIDTH-1:0] = store_dma_header[i].num_words;
                end
                if (est_rd_addr.regs.reg_idx == 5'(3 + 2 * i)) begin
                    rd_data_int[GLB_ADDR_WIDTH:0] =
                        {store_dma_header[i].start_addr, store_dma_header[i].valid};
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wst_wr_en         <= 1'b0;
            wst_rd_en         <= 1'b0;
            est_rd_data_valid <= 1'b0;
        end else begin
            wst_wr_en         <= est_wr_en && !wr_match;
            wst_rd_en         <= est_rd_en && !rd_match;
            est_rd_data_valid <= rd_match || wst_rd_data_valid; // only one read is in flight.
        end
    end

    always_ff @(posedge clk) begin
        wst_wr_addr <= est_wr_addr;
        wst_wr_data <= est_wr_data;
        wst_rd_addr <= est_rd_addr;
        est_rd_data <= rd_match ? rd_data_int : wst_rd_data;
    end

    assert property (@(posedge clk) disable iff (reset) !(rd_match && wst_rd_data_valid))
        else $error("tile %0d got a local read while a west answer was returning", TILE_ID);

endmodule

/* hdl/glb_wb_cfg_bridge.sv */
// Wishbone classic slave with one transaction in flight; no byte selects, bursts or pipelining.
module glb_wb_cfg_bridge
    import glb_cfg_pkg::*;
#(
    parameter int RD_TIMEOUT = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [CFG_ADDR_WIDTH-1:0] adr,
    input  logic [CFG_DATA_WIDTH-1:0] dat_w,
    output logic [CFG_DATA_WIDTH-1:0] dat_r,
    output logic                      ack,
    output logic                      cfg_wr_en,
    output cfg_addr_t                 cfg_wr_addr,
    output logic [CFG_DATA_WIDTH-1:0] cfg_wr_data,
    output logic                      cfg_rd_en,
    output cfg_addr_t                 cfg_rd_addr,
    input  logic [CFG_DATA_WIDTH-1:0] cfg_rd_data,
    input  logic                      cfg_rd_data_valid
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RD, ACK} state_t;

    state_t                          state;
    logic [$clog2(RD_TIMEOUT+1)-1:0] wait_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            ack       <= 1'b0;
            cfg_wr_en <= 1'b0;
            cfg_rd_en <= 1'b0;
            wait_cnt  <= '0;
        end else begin
            cfg_wr_en <= 1'b0; // enables and ack are single-cycle pulses.
            cfg_rd_en <= 1'b0;
            ack       <= 1'b0;
            case (state)
                IDLE: begin
                    if (cyc && stb) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    wait_cnt <= '0;
                    if (we) begin
                        cfg_wr_en <= 1'b1; // writes are posted, so ack goes with the pulse.
                        ack       <= 1'b1;
                        state     <= ACK;
                    end else begin
                        cfg_rd_en <= 1'b1;
                        state     <= WAIT_RD;
                    end
                end
                WAIT_RD: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (cfg_rd_data_valid || wait_cnt == RD_TIMEOUT - 1) begin
                        ack   <= 1'b1;
                        state <= ACK;
                    end
                end
                default: begin
                    state <= IDLE; // master drops stb after seeing ack.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cyc && stb) begin
            cfg_wr_addr <= adr;
            cfg_rd_addr <= adr;
            cfg_wr_data <= dat_w;
        end
        if (state == WAIT_RD) begin
            dat_r <= cfg_rd_data_valid ? cfg_rd_data : '0; // zero is returned on timeout.
        end
    end

    assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
        else $error("ack raised outside a wishbone cycle");

endmodule

/* hdl/glb_dma_pkg.sv */
// Store DMA header layout and bank sizing; the bank address wraps at BANK_DEPTH words.
package glb_dma_pkg;

    localparam int QUEUE_DEPTH         = 4;
    localparam int GLB_ADDR_WIDTH      = 7; // bank word address.
    localparam int MAX_NUM_WORDS_WIDTH = 8;
    localparam int BANK_DEPTH          = 2 ** GLB_ADDR_WIDTH;

    typedef struct packed {
        logic                           valid;
        logic [GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_st_header_t;

endpackage

/* hdl/glb_cfg_pkg.sv */
// Configuration bus widths and address views; the byte offset bits are carried but never decoded.
package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH = 16; // wishbone and configuration address width.
    localparam int CFG_DATA_WIDTH = 32;
    localparam int TILE_SEL_WIDTH = 4;

    // one address word seen as a register access or a bank access.
    typedef union packed {
        struct packed {
            logic [1:0]                rsvd;
            logic                      is_bank;  // zero in this view.
            logic [TILE_SEL_WIDTH-1:0] tile;
            logic [1:0]                unused;
            logic [4:0]                reg_idx;
            logic [1:0]                byte_off;
        } regs;
        struct packed {
            logic [1:0]                rsvd;
            logic                      is_bank;  // one in this view.
            logic [TILE_SEL_WIDTH-1:0] tile;
            logic [6:0]                word;     // matches the 128-word bank.
            logic [1:0]                byte_off;
        } bank;
    } cfg_addr_t;

endpackage
